/* source/smq_pkg.sv */
//////////////////////////////////////////////////
// widths and types shared by the memory queue
// tags must be unique among outstanding commands
// queue depth is a module parameter set at the top
//////////////////////////////////////////////////

`default_nettype none

package smq_pkg;

   //////////////////////////////////////////////////
   // field widths
   //////////////////////////////////////////////////

   // destination address
   localparam int ADDR_W = 16;
   // write data, also carries read and write responses
   localparam int DATA_W = 16;
   // source tag, bounds the depth to 2**TAG_W entries
   localparam int TAG_W  = 4;

   //////////////////////////////////////////////////
   // vector types
   //////////////////////////////////////////////////

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [TAG_W-1:0]  tag_t;

   // per-entry lifecycle
   //   st_req   waiting to be sent to the destination
   //   st_wait  sent, destination response outstanding
   //   st_resp  response captured, waiting for its turn
   //   st_done  returned to the source, slot frees next edge
   typedef enum logic [1:0] {
      st_req,
      st_wait,
      st_resp,
      st_done
   } entry_state_e;

endpackage

`default_nettype wire

/* source/smq_entry_table.sv */
//////////////////////////////////////////////////
// entry storage and per-entry FSM of the queue
// source must not send when full or reuse a live tag
// destination answers each command once, same tag
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module smq_entry_table import smq_pkg::*; #(
   parameter int num_entries = 16
) (
   input  logic                   clk,
   input  logic                   reset,
   // source command
   input  logic                   src_cmd_val,
   input  logic                   src_is_read,
   input  tag_t                   src_tag,
   input  addr_t                  src_addr,
   input  data_t                  src_data,
   // destination response
   input  logic                   dest_resp_val,
   input  tag_t                   dest_resp_tag,
   input  data_t                  dest_resp_data,
   // one-hot grants from issue and return
   input  logic [num_entries-1:0] grant_req,
   input  logic [num_entries-1:0] grant_resp,
   // stored command fields
   output logic [num_entries-1:0] entry_is_read,
   output addr_t                  entry_addr [num_entries],
   output tag_t                   entry_tag  [num_entries],
   output data_t                  entry_data [num_entries],
   // per-entry status
   output logic [num_entries-1:0] req_pending,
   output logic [num_entries-1:0] resp_pending,
   output logic [num_entries-1:0] older_pending,
   output logic [num_entries-1:0] match_older_pending
);

   logic [num_entries-1:0] entry_val;
   entry_state_e           entry_state [num_entries];
   // row i holds the entries that arrived before entry i
   logic [num_entries-1:0] older_row   [num_entries];
   // same as older_row, limited to the same address
   logic [num_entries-1:0] match_row   [num_entries];

   // valid and not yet returned
   logic [num_entries-1:0] live_vec;
   logic [num_entries-1:0] free_vec;
   logic [num_entries-1:0] new_slot;
   logic [num_entries-1:0] alloc;
   logic [num_entries-1:0] addr_match;
   logic [num_entries-1:0] resp_hit;
   logic [num_entries-1:0] live_tag_hit;

   //////////////////////////////////////////////////
   // status decode
   //////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < num_entries; i++) begin
         live_vec[i]            = entry_val[i] & (entry_state[i] != st_done);
         req_pending[i]         = entry_val[i] & (entry_state[i] == st_req);
         resp_pending[i]        = entry_val[i] & (entry_state[i] == st_resp);
         older_pending[i]       = entry_val[i] & (|older_row[i]);
         match_older_pending[i] = entry_val[i] & (|match_row[i]);
         addr_match[i]          = (entry_addr[i] == src_addr);
         // only an issued entry can take a destination response
         resp_hit[i]            = dest_resp_val & entry_val[i] &
                                  (entry_state[i] == st_wait) &
                                  (entry_tag[i] == dest_resp_tag);
         live_tag_hit[i]        = live_vec[i] & (entry_tag[i] == src_tag);
      end
   end

   // a done entry frees at this edge, so its slot can be reused at once
   assign free_vec = ~live_vec;
   // lowest free slot, isolated as the lowest set bit
   assign new_slot = free_vec & (~free_vec + 1'b1);
   assign alloc    = new_slot & {num_entries{src_cmd_val}};

   //////////////////////////////////////////////////
   // valid bits
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         entry_val <= '0;
      end else begin
         entry_val <= live_vec | alloc;
      end
   end

   //////////////////////////////////////////////////
   // fields, age rows and per-entry FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      for (int i = 0; i < num_entries; i++) begin
         if (alloc[i]) begin
            entry_is_read[i] <= src_is_read;
            entry_addr[i]    <= src_addr;
            entry_tag[i]     <= src_tag;
            entry_data[i]    <= src_data;
            entry_state[i]   <= st_req;
            // everything still live is older than the new command
            older_row[i]     <= live_vec;
            match_row[i]     <= live_vec & addr_match;
         end else if (entry_val[i]) begin
            // drop older entries once they have been returned
            older_row[i] <= older_row[i] & live_vec;
            match_row[i] <= match_row[i] & live_vec;
            case (entry_state[i])
               st_req: begin
                  if (grant_req[i]) begin
                     entry_state[i] <= st_wait;
                  end
               end
               st_wait: begin
                  // response data replaces the write data
                  if (resp_hit[i]) begin
                     entry_state[i] <= st_resp;
                     entry_data[i]  <= dest_resp_data;
                  end
               end
               st_resp: begin
                  if (grant_resp[i]) begin
                     entry_state[i] <= st_done;
                  end
               end
               default: begin
                  entry_state[i] <= st_done;
               end
            endcase
         end
      end
   end

   //////////////////////////////////////////////////
   // source and destination protocol checks
   //////////////////////////////////////////////////

   // source sent a command with every slot in use
   a_not_full : assert property (@(posedge clk) disable iff (reset)
      src_cmd_val |-> (|free_vec))
      else $error("command received while the queue is full");

   // source reused a tag that has not been returned yet
   a_tag_free : assert property (@(posedge clk) disable iff (reset)
      src_cmd_val |-> !(|live_tag_hit))
      else $error("source tag %0h is still outstanding", src_tag);

   // destination answered a tag that was never issued
   a_resp_known : assert property (@(posedge clk) disable iff (reset)
      dest_resp_val |-> (|resp_hit))
      else $error("destination response tag %0h has no waiting entry", dest_resp_tag);

endmodule

`default_nettype wire

/* source/smq_issue_sched.sv */
//////////////////////////////////////////////////
// picks one entry per cycle for the destination
// reads pass writes but keep same-address order
// command is registered and valid for one cycle
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module smq_issue_sched import smq_pkg::*; #(
   parameter int num_entries = 16
) (
   input  logic                   clk,
   input  logic                   reset,
   // entry status and fields
   input  logic [num_entries-1:0] req_pending,
   input  logic [num_entries-1:0] entry_is_read,
   input  logic [num_entries-1:0] match_older_pending,
   input  addr_t                  entry_addr [num_entries],
   input  tag_t                   entry_tag  [num_entries],
   input  data_t                  entry_data [num_entries],
   // one-hot issue grant back to the table
   output logic [num_entries-1:0] grant_req,
   // destination command
   output logic                   dest_cmd_val,
   output logic                   dest_is_read,
   output addr_t                  dest_addr,
   output data_t                  dest_data,
   output tag_t                   dest_tag
);

   logic [num_entries-1:0] entry_rdy;
   logic [num_entries-1:0] read_rdy;
   logic [num_entries-1:0] write_blk;
   logic [num_entries-1:0] issue_ok;

   //////////////////////////////////////////////////
   // ordering rules
   //////////////////////////////////////////////////

   // any older entry to the same address holds this one back
   assign entry_rdy = req_pending & ~match_older_pending;

   // only reads that can really go count against writes
   // a blocked read would otherwise stall a write forever
   assign read_rdy  = entry_rdy & entry_is_read;

   // writes wait while any read is ready
   assign write_blk = ~entry_is_read & {num_entries{|read_rdy}};
   assign issue_ok  = entry_rdy & ~write_blk;

   // lowest index wins
   assign grant_req = issue_ok & (~issue_ok + 1'b1);

   //////////////////////////////////////////////////
   // destination command register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         dest_cmd_val <= 1'b0;
      end else begin
         dest_cmd_val <= |grant_req;
      end
   end

   // payload only moves on a grant
   always_ff @(posedge clk) begin
      for (int i = 0; i < num_entries; i++) begin
         if (grant_req[i]) begin
            dest_is_read <= entry_is_read[i];
            dest_addr    <= entry_addr[i];
            dest_data    <= entry_data[i];
            dest_tag     <= entry_tag[i];
         end
      end
   end

endmodule

`default_nettype wire

/* source/smq_resp_return.sv */
//////////////////////////////////////////////////
// returns responses to the source in arrival order
// at most one registered response per cycle
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module smq_resp_return import smq_pkg::*; #(
   parameter int num_entries = 16
) (
   input  logic                   clk,
   input  logic                   reset,
   // entry status and fields
   input  logic [num_entries-1:0] resp_pending,
   input  logic [num_entries-1:0] older_pending,
   input  tag_t                   entry_tag  [num_entries],
   input  data_t                  entry_data [num_entries],
   // one-hot return grant back to the table
   output logic [num_entries-1:0] grant_resp,
   // source response
   output logic                   src_resp_val,
   output tag_t                   src_resp_tag,
   output data_t                  src_resp_data
);

   logic [num_entries-1:0] ret_rdy;

   // only the oldest live entry may return
   assign ret_rdy    = resp_pending & ~older_pending;
   assign grant_resp = ret_rdy & (~ret_rdy + 1'b1);

   always_ff @(posedge clk) begin
      if (reset) begin
         src_resp_val <= 1'b0;
      end else begin
         src_resp_val <= |grant_resp;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < num_entries; i++) begin
         if (grant_resp[i]) begin
            src_resp_tag  <= entry_tag[i];
            src_resp_data <= entry_data[i];
         end
      end
   end

   // the age rows leave at most one held response without an older entry
   a_single_oldest : assert property (@(posedge clk) disable iff (reset)
      $onehot0(ret_rdy))
      else $error("more than one entry is oldest: %b", ret_rdy);

endmodule

`default_nettype wire

/* source/smq_top.sv */
//////////////////////////////////////////////////
// memory queue top, no ready signals on any side
// num_entries from 2 up to 2**TAG_W
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module smq_top import smq_pkg::*; #(
   parameter int num_entries = 16
) (
   input  logic  clk,
   input  logic  reset,
   // source command
   input  logic  src_cmd_val,
   input  logic  src_is_read,
   input  tag_t  src_tag,
   input  addr_t src_addr,
   input  data_t src_data,
   // source response
   output logic  src_resp_val,
   output tag_t  src_resp_tag,
   output data_t src_resp_data,
   // destination command
   output logic  dest_cmd_val,
   output logic  dest_is_read,
   output addr_t dest_addr,
   output data_t dest_data,
   output tag_t  dest_tag,
   // destination response
   input  logic  dest_resp_val,
   input  tag_t  dest_resp_tag,
   input  data_t dest_resp_data
);

   logic [num_entries-1:0] entry_is_read;
   addr_t                  entry_addr [num_entries];
   tag_t                   entry_tag  [num_entries];
   data_t                  entry_data [num_entries];
   logic [num_entries-1:0] req_pending;
   logic [num_entries-1:0] resp_pending;
   logic [num_entries-1:0] older_pending;
   logic [num_entries-1:0] match_older_pending;
   logic [num_entries-1:0] grant_req;
   logic [num_entries-1:0] grant_resp;

   //////////////////////////////////////////////////
   // decode and allocation
   //////////////////////////////////////////////////

   smq_entry_table #(.num_entries(num_entries)) u_entry_table (
      .clk                 (clk),
      .reset               (reset),
      .src_cmd_val         (src_cmd_val),
      .src_is_read         (src_is_read),
      .src_tag             (src_tag),
      .src_addr            (src_addr),
      .src_data            (src_data),
      .dest_resp_val       (dest_resp_val),
      .dest_resp_tag       (dest_resp_tag),
      .dest_resp_data      (dest_resp_data),
      .grant_req           (grant_req),
      .grant_resp          (grant_resp),
      .entry_is_read       (entry_is_read),
      .entry_addr          (entry_addr),
      .entry_tag           (entry_tag),
      .entry_data          (entry_data),
      .req_pending         (req_pending),
      .resp_pending        (resp_pending),
      .older_pending       (older_pending),
      .match_older_pending (match_older_pending)
   );

   // issue to the destination
   smq_issue_sched #(.num_entries(num_entries)) u_issue_sched (
      .clk                 (clk),
      .reset               (reset),
      .req_pending         (req_pending),
      .entry_is_read       (entry_is_read),
      .match_older_pending (match_older_pending),
      .entry_addr          (entry_addr),
      .entry_tag           (entry_tag),
      .entry_data          (entry_data),
      .grant_req           (grant_req),
      .dest_cmd_val        (dest_cmd_val),
      .dest_is_read        (dest_is_read),
      .dest_addr           (dest_addr),
      .dest_data           (dest_data),
      .dest_tag            (dest_tag)
   );

   // in-order return to the source
   smq_resp_return #(.num_entries(num_entries)) u_resp_return (
      .clk           (clk),
      .reset         (reset),
      .resp_pending  (resp_pending),
      .older_pending (older_pending),
      .entry_tag     (entry_tag),
      .entry_data    (entry_data),
      .grant_resp    (grant_resp),
      .src_resp_val  (src_resp_val),
      .src_resp_tag  (src_resp_tag),
      .src_resp_data (src_resp_data)
   );

endmodule

`default_nettype wire

/* dv/smq_tb.sv */
//////////////////////////////////////////////////
// testbench for the memory queue, random traffic
// destination answers out of order, four addresses
// run time bounded by a watchdog
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module smq_tb import smq_pkg::*; ();

   localparam int num_entries = 16;
   localparam int num_cmds    = 400;
   localparam int clk_period  = 40;
   localparam int timeout_ns  = num_cmds * 64 * clk_period;

   logic  clk;
   logic  reset;
   logic  src_cmd_val;
   logic  src_is_read;
   tag_t  src_tag;
   addr_t src_addr;
   data_t src_data;
   logic  src_resp_val;
   tag_t  src_resp_tag;
   data_t src_resp_data;
   logic  dest_cmd_val;
   logic  dest_is_read;
   addr_t dest_addr;
   data_t dest_data;
   tag_t  dest_tag;
   logic  dest_resp_val;
   tag_t  dest_resp_tag;
   data_t dest_resp_data;

   // reference, one slot per command in arrival order
   logic  cmd_is_read [num_cmds];
   addr_t cmd_addr    [num_cmds];
   data_t cmd_data    [num_cmds];
   tag_t  cmd_tag     [num_cmds];
   data_t cmd_expect  [num_cmds];
   logic  cmd_issued  [num_cmds];
   // tag to arrival index, valid while busy
   int    tag_seq     [2**TAG_W];
   logic  tag_busy    [2**TAG_W];
   addr_t addr_tab    [4];
   // memory as the source should see it, in arrival order
   data_t ref_mem     [4];
   // destination model state
   data_t dest_mem    [4];
   tag_t  dq_tag      [$];
   logic  dq_is_read  [$];
   addr_t dq_addr     [$];
   data_t dq_data     [$];

   int n_sent;
   int n_returned;
   int n_outstanding;
   int n_errors;
   logic [31:0] rng;

   smq_top #(.num_entries(num_entries)) u_dut (
      .clk            (clk),
      .reset          (reset),
      .src_cmd_val    (src_cmd_val),
      .src_is_read    (src_is_read),
      .src_tag        (src_tag),
      .src_addr       (src_addr),
      .src_data       (src_data),
      .src_resp_val   (src_resp_val),
      .src_resp_tag   (src_resp_tag),
      .src_resp_data  (src_resp_data),
      .dest_cmd_val   (dest_cmd_val),
      .dest_is_read   (dest_is_read),
      .dest_addr      (dest_addr),
      .dest_data      (dest_data),
      .dest_tag       (dest_tag),
      .dest_resp_val  (dest_resp_val),
      .dest_resp_tag  (dest_resp_tag),
      .dest_resp_data (dest_resp_data)
   );

   initial clk = 1'b0;
   always #(clk_period / 2) clk = ~clk;

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   // upper half of the state, low bits of an lcg repeat quickly
   function automatic logic [15:0] lcg_next();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng[31:16];
   endfunction

   // index into the address table, -1 for an address never sent
   function automatic int addr_slot(input addr_t a);
      for (int k = 0; k < 4; k++) begin
         if (addr_tab[k] == a) begin
            return k;
         end
      end
      return -1;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      n_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
   endtask

   //////////////////////////////////////////////////
   // output monitor, runs 1 ns after the edge
   //////////////////////////////////////////////////

   task automatic observe_outputs();
      int seq;
      if (src_resp_val) begin
         if (n_returned >= n_sent) begin
            n_errors++;
            $display("source response tag %0h with no command outstanding", src_resp_tag);
         end else begin
            if (src_resp_tag !== cmd_tag[n_returned]) begin
               report_mismatch("resp_tag", cmd_tag[n_returned], src_resp_tag);
            end
            if (src_resp_data !== cmd_expect[n_returned]) begin
               report_mismatch(cmd_is_read[n_returned] ? "read_data" : "write_data",
                               cmd_expect[n_returned], src_resp_data);
            end
            if (!cmd_issued[n_returned]) begin
               n_errors++;
               $display("command %0d returned before it was issued", n_returned);
            end
            tag_busy[cmd_tag[n_returned]] = 1'b0;
            n_outstanding--;
            n_returned++;
         end
      end
      if (dest_cmd_val) begin
         if (!tag_busy[dest_tag]) begin
            n_errors++;
            $display("destination command with tag %0h that is not outstanding", dest_tag);
         end else begin
            seq = tag_seq[dest_tag];
            if (cmd_issued[seq]) begin
               n_errors++;
               $display("command %0d issued to the destination twice", seq);
            end
            if (dest_is_read !== cmd_is_read[seq]) begin
               report_mismatch("dest_is_read", cmd_is_read[seq], dest_is_read);
            end
            if (dest_addr !== cmd_addr[seq]) begin
               report_mismatch("dest_addr", cmd_addr[seq], dest_addr);
            end
            if (!cmd_is_read[seq] && dest_data !== cmd_data[seq]) begin
               report_mismatch("dest_data", cmd_data[seq], dest_data);
            end
            // same address order, reads only wait on earlier writes
            for (int j = 0; j < seq; j++) begin
               if (cmd_addr[j] == cmd_addr[seq] && !cmd_issued[j] &&
                   (!cmd_is_read[seq] || !cmd_is_read[j])) begin
                  n_errors++;
                  $display("command %0d issued ahead of earlier command %0d", seq, j);
               end
            end
            cmd_issued[seq] = 1'b1;
            dq_tag.push_back(dest_tag);
            dq_is_read.push_back(dest_is_read);
            dq_addr.push_back(dest_addr);
            dq_data.push_back(dest_data);
         end
      end
   endtask

   //////////////////////////////////////////////////
   // source and destination drivers, 2 ns after the edge
   //////////////////////////////////////////////////

   task automatic drive_inputs();
      logic [15:0] r;
      logic [15:0] d;
      int k;
      int t;
      int idx;
      src_cmd_val   = 1'b0;
      dest_resp_val = 1'b0;
      r = lcg_next();
      // source sends about three cycles in four while a slot is free
      if (n_sent < num_cmds && n_outstanding < num_entries && r[1:0] != 2'd0) begin
         d = lcg_next();
         k = r[5:4];
         t = 0;
         while (tag_busy[t]) begin
            t++;
         end
         src_cmd_val = 1'b1;
         src_is_read = r[8];
         src_tag     = tag_t'(t);
         src_addr    = addr_tab[k];
         src_data    = d;
         cmd_is_read[n_sent] = r[8];
         cmd_addr[n_sent]    = addr_tab[k];
         cmd_data[n_sent]    = d;
         cmd_tag[n_sent]     = tag_t'(t);
         cmd_issued[n_sent]  = 1'b0;
         // a read sees the last earlier write, a write echoes its data
         if (r[8]) begin
            cmd_expect[n_sent] = ref_mem[k];
         end else begin
            cmd_expect[n_sent] = d;
            ref_mem[k] = d;
         end
         tag_busy[t] = 1'b1;
         tag_seq[t]  = n_sent;
         n_sent++;
         n_outstanding++;
      end
      r = lcg_next();
      // destination answers a random outstanding command, 5 cycles in 8
      if (dq_tag.size() > 0 && r[2:0] < 3'd5) begin
         idx = int'(r[15:4]) % dq_tag.size();
         k   = addr_slot(dq_addr[idx]);
         dest_resp_val = 1'b1;
         dest_resp_tag = dq_tag[idx];
         if (k < 0) begin
            dest_resp_data = dq_addr[idx] ^ 16'h5a5a;
         end else if (dq_is_read[idx]) begin
            dest_resp_data = dest_mem[k];
         end else begin
            dest_mem[k]    = dq_data[idx];
            dest_resp_data = dq_data[idx];
         end
         dq_tag.delete(idx);
         dq_is_read.delete(idx);
         dq_addr.delete(idx);
         dq_data.delete(idx);
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      reset          = 1'b1;
      src_cmd_val    = 1'b0;
      src_is_read    = 1'b0;
      src_tag        = '0;
      src_addr       = '0;
      src_data       = '0;
      dest_resp_val  = 1'b0;
      dest_resp_tag  = '0;
      dest_resp_data = '0;
      rng            = 32'h35ed;
      n_sent         = 0;
      n_returned     = 0;
      n_outstanding  = 0;
      n_errors       = 0;
      addr_tab[0]    = 16'h0010;
      addr_tab[1]    = 16'h0124;
      addr_tab[2]    = 16'h2300;
      addr_tab[3]    = 16'hbeef;
      for (int k = 0; k < 4; k++) begin
         ref_mem[k]  = addr_tab[k] ^ 16'h5a5a;
         dest_mem[k] = addr_tab[k] ^ 16'h5a5a;
      end
      for (int t = 0; t < 2**TAG_W; t++) begin
         tag_busy[t] = 1'b0;
         tag_seq[t]  = 0;
      end
      // both valids stay low in reset and the first cycle after it
      for (int c = 0; c <= 10; c++) begin
         @(posedge clk);
         #1;
         if (dest_cmd_val !== 1'b0) begin
            report_mismatch("reset_dest_cmd_val", 32'd0, dest_cmd_val);
         end
         if (src_resp_val !== 1'b0) begin
            report_mismatch("reset_src_resp_val", 32'd0, src_resp_val);
         end
         #1;
         if (c == 9) begin
            reset = 1'b0;
         end
      end
      while (n_returned < num_cmds) begin
         @(posedge clk);
         #1;
         observe_outputs();
         #1;
         drive_inputs();
      end
      // idle tail, nothing more may come out
      src_cmd_val   = 1'b0;
      dest_resp_val = 1'b0;
      repeat (4) begin
         @(posedge clk);
         #1;
         observe_outputs();
      end
      if (dq_tag.size() != 0) begin
         n_errors++;
         $display("%0d destination commands left unanswered", dq_tag.size());
      end
      $display("errors %0d, commands sent %0d, responses returned %0d",
               n_errors, n_sent, n_returned);
      if (n_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // hang guard, sized for 64 cycles per command
   initial begin
      #(timeout_ns);
      $display("watchdog expired, only %0d of %0d responses returned",
               n_returned, num_cmds);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
source/smq_pkg.sv
source/smq_entry_table.sv
source/smq_issue_sched.sv
source/smq_resp_return.sv
source/smq_top.sv
dv/smq_tb.sv
